/* source/hni_qos_pkg.sv */
package hni_qos_pkg;

    // priority class of a request and the pool it is charged to
    typedef enum logic {
        CLASS_LOW  = 1'b0,
        CLASS_HIGH = 1'b1
    } qos_class_e;

    typedef enum logic [1:0] {
        PCRD_NONE = 2'd0,
        PCRD_LOW  = 2'd1,
        PCRD_HIGH = 2'd2
    } pcrd_type_e;

    typedef enum logic [1:0] {
        DEC_NONE,
        DEC_DYN,
        DEC_STATIC,
        DEC_RETRY
    } alloc_decision_e;

    // qos at or above this is high class
    localparam logic [3:0] QOS_HIGH_MIN   = 4'd8;
    localparam logic [3:0] GRANT_QOS_HIGH = 4'd15;
    localparam logic [3:0] GRANT_QOS_LOW  = 4'd0;

    localparam int DEF_NUM_ENTRIES = 8;
    localparam int DEF_HIGH_POOL   = 4;
    localparam int DEF_LOW_POOL    = 4;
    localparam int DEF_QUEUE_DEPTH = 4;
    localparam int DEF_RETRY_CNT_W = 4;

    typedef struct packed {
        logic [3:0] srcid;
        logic [7:0] txnid;
        logic [3:0] qos;
        logic       allowretry;
        logic       tracetag;
    } req_flit_t;

    typedef struct packed {
        logic [3:0] srcid;
        logic [7:0] txnid;
        logic [3:0] qos;
        logic       tracetag;
        pcrd_type_e pcrdtype;
    } retry_ack_t;

    typedef struct packed {
        logic [3:0] qos;
        pcrd_type_e pcrdtype;
    } grant_t;

endpackage

/* source/qos_pool_tracker.sv */
`timescale 1ns/1ns

module qos_pool_tracker
    import hni_qos_pkg::*;
#(
    parameter int NUM_ENTRIES = DEF_NUM_ENTRIES,
    parameter int HIGH_POOL   = DEF_HIGH_POOL,
    parameter int LOW_POOL    = DEF_LOW_POOL,
    localparam int IDX_W      = $clog2(NUM_ENTRIES)
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  req_flit_t       req,
    input  logic [IDX_W-1:0] alloc_idx,
    input  logic            retire_valid,
    input  logic [IDX_W-1:0] retire_idx,
    input  logic            retire_convert,
    output alloc_decision_e decision,
    output qos_class_e      req_class,
    output qos_class_e      retire_class
);

    localparam int HI_W = $clog2(HIGH_POOL + 1);
    localparam int LO_W = $clog2(LOW_POOL + 1);

    logic [HI_W-1:0] high_cnt;
    logic [LO_W-1:0] low_cnt;
    logic            high_full;
    logic            low_full;
    logic            take_high;
    logic            high_inc;
    logic            high_dec;
    logic            low_inc;
    logic            low_dec;
    qos_class_e      class_q [NUM_ENTRIES];

    assign req_class = qos_class_e'(req.qos >= QOS_HIGH_MIN);
    assign high_full = (high_cnt == HI_W'(HIGH_POOL));
    assign low_full  = (low_cnt == LO_W'(LOW_POOL));

    // high requests spill into the low pool once their own is full
    assign take_high = (req_class == CLASS_HIGH) && !high_full;

    always_comb begin
        if (!req_valid) begin
            decision = DEC_NONE;
        end else if (!req.allowretry) begin
            decision = DEC_STATIC;
        end else if (take_high || !low_full) begin
            decision = DEC_DYN;
        end else begin
            decision = DEC_RETRY;
        end
    end

    assign retire_class = class_q[retire_idx];

    assign high_inc = (decision == DEC_DYN) && take_high;
    assign low_inc  = (decision == DEC_DYN) && !take_high;
    // converted entries stay charged to their pool
    assign high_dec = retire_valid && !retire_convert && (retire_class == CLASS_HIGH);
    assign low_dec  = retire_valid && !retire_convert && (retire_class == CLASS_LOW);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            high_cnt <= '0;
            low_cnt  <= '0;
        end else begin
            if (high_inc && !high_dec) begin
                high_cnt <= high_cnt + 1'b1;
            end else if (high_dec && !high_inc) begin
                high_cnt <= high_cnt - 1'b1;
            end
            if (low_inc && !low_dec) begin
                low_cnt <= low_cnt + 1'b1;
            end else if (low_dec && !low_inc) begin
                low_cnt <= low_cnt - 1'b1;
            end
        end
    end

    // charged pool per entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                class_q[i] <= CLASS_LOW;
            end
        end else if (decision == DEC_DYN) begin
            class_q[alloc_idx] <= qos_class_e'(take_high);
        end
    end

endmodule

/* source/mshr_entry_alloc.sv */
`timescale 1ns/1ns

module mshr_entry_alloc
    import hni_qos_pkg::*;
#(
    parameter int NUM_ENTRIES = DEF_NUM_ENTRIES,
    localparam int IDX_W      = $clog2(NUM_ENTRIES)
) (
    input  logic             clk,
    input  logic             rst,
    input  alloc_decision_e  decision,
    input  logic             retire_valid,
    input  logic [IDX_W-1:0] retire_idx,
    input  logic             retire_convert,
    output logic             alloc_en,
    output logic [IDX_W-1:0] alloc_idx
);

    logic [NUM_ENTRIES-1:0] valid_q;
    logic [NUM_ENTRIES-1:0] static_q;
    logic [NUM_ENTRIES-1:0] dyn_avail;
    logic [NUM_ENTRIES-1:0] st_avail;
    logic [NUM_ENTRIES-1:0] alloc_vec;
    logic [NUM_ENTRIES-1:0] retire_vec;
    logic                   dyn_found;
    logic                   st_found;
    logic [IDX_W-1:0]       dyn_idx;
    logic [IDX_W-1:0]       st_idx;

    // returns {found, index of lowest set bit}
    function automatic logic [IDX_W:0] pick_lowest(input logic [NUM_ENTRIES-1:0] vec);
        logic [IDX_W:0] res;
        res = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                res = {1'b1, IDX_W'(i)};
            end
        end
        return res;
    endfunction

    // reserved entries are kept for non-retryable requests
    assign dyn_avail = ~valid_q & ~static_q;
    assign st_avail  = ~valid_q & static_q;

    assign {dyn_found, dyn_idx} = pick_lowest(dyn_avail);
    assign {st_found, st_idx}   = pick_lowest(st_avail);

    assign alloc_en  = ((decision == DEC_DYN) && dyn_found) ||
                       ((decision == DEC_STATIC) && st_found);
    assign alloc_idx = (decision == DEC_STATIC) ? st_idx : dyn_idx;

    always_comb begin
        alloc_vec  = '0;
        retire_vec = '0;
        if (alloc_en) begin
            alloc_vec[alloc_idx] = 1'b1;
        end
        if (retire_valid) begin
            retire_vec[retire_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= '0;
            static_q <= '0;
        end else begin
            valid_q  <= (valid_q & ~retire_vec) | alloc_vec;
            static_q <= (static_q & ~alloc_vec) | (retire_vec & {NUM_ENTRIES{retire_convert}});
        end
    end

endmodule

/* source/retry_grant_ctrl.sv */
`timescale 1ns/1ns

module retry_grant_ctrl
    import hni_qos_pkg::*;
#(
    parameter int RETRY_CNT_W = DEF_RETRY_CNT_W
) (
    input  logic            clk,
    input  logic            rst,
    input  alloc_decision_e decision,
    input  qos_class_e      req_class,
    input  logic            retire_valid,
    input  qos_class_e      retire_class,
    output logic            retire_convert,
    output logic            grant_push,
    output grant_t          grant
);

    logic [RETRY_CNT_W-1:0] high_wait;
    logic [RETRY_CNT_W-1:0] low_wait;
    logic                   retry_high;
    logic                   retry_low;
    logic                   grant_high;
    logic                   grant_low;

    assign retry_high = (decision == DEC_RETRY) && (req_class == CLASS_HIGH);
    assign retry_low  = (decision == DEC_RETRY) && (req_class == CLASS_LOW);

    // high waiters win any retire, low waiters only a low one
    assign grant_high = retire_valid && (high_wait != '0);
    assign grant_low  = retire_valid && (retire_class == CLASS_LOW) &&
                        (high_wait == '0) && (low_wait != '0);

    assign retire_convert = grant_high || grant_low;
    assign grant_push     = grant_high || grant_low;

    always_comb begin
        if (grant_high) begin
            grant = '{qos: GRANT_QOS_HIGH, pcrdtype: PCRD_HIGH};
        end else begin
            grant = '{qos: GRANT_QOS_LOW, pcrdtype: PCRD_LOW};
        end
    end

    // saturating waiter counts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            high_wait <= '0;
            low_wait  <= '0;
        end else begin
            if (retry_high && !grant_high && !(&high_wait)) begin
                high_wait <= high_wait + 1'b1;
            end else if (grant_high && !retry_high) begin
                high_wait <= high_wait - 1'b1;
            end
            if (retry_low && !grant_low && !(&low_wait)) begin
                low_wait <= low_wait + 1'b1;
            end else if (grant_low && !retry_low) begin
                low_wait <= low_wait - 1'b1;
            end
        end
    end

endmodule

/* source/rsp_queue.sv */
`timescale 1ns/1ns

module rsp_queue #(
    parameter type rec_t  = logic [7:0],
    parameter int DEPTH   = 4,
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int CNT_W  = $clog2(DEPTH + 1)
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    input  rec_t din,
    output rec_t dout,
    output logic valid,
    output logic full
);

    rec_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign valid   = (count != '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_pop  = pop && valid;
    // a full queue still takes a push when it is popped in the same cycle
    assign do_push = push && (!full || do_pop);
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* source/hni_qos_top.sv */
`timescale 1ns/1ns

module hni_qos_top
    import hni_qos_pkg::*;
#(
    parameter int NUM_ENTRIES = DEF_NUM_ENTRIES,
    parameter int HIGH_POOL   = DEF_HIGH_POOL,
    parameter int LOW_POOL    = DEF_LOW_POOL,
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH,
    parameter int RETRY_CNT_W = DEF_RETRY_CNT_W,
    localparam int IDX_W      = $clog2(NUM_ENTRIES)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  req_flit_t        req,
    input  logic             retire_valid,
    input  logic [IDX_W-1:0] retire_idx,
    input  logic             retryack_won,
    input  logic             pcrdgnt_won,
    output logic             alloc_en,
    output logic [IDX_W-1:0] alloc_idx,
    output logic             retry,
    output logic             retryack_valid,
    output retry_ack_t       retryack,
    output logic             pcrdgnt_valid,
    output grant_t           pcrdgnt
);

    alloc_decision_e decision;
    qos_class_e      req_class;
    qos_class_e      retire_class;
    logic            retire_convert;
    logic            grant_push;
    grant_t          grant_rec;
    retry_ack_t      ack_rec;

    assign retry = (decision == DEC_RETRY);

    // retry ack tells the requester which credit class to wait for
    assign ack_rec = '{
        srcid:    req.srcid,
        txnid:    req.txnid,
        qos:      req.qos,
        tracetag: req.tracetag,
        pcrdtype: pcrd_type_e'((req_class == CLASS_HIGH) ? PCRD_HIGH : PCRD_LOW)
    };

    qos_pool_tracker #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .HIGH_POOL  (HIGH_POOL),
        .LOW_POOL   (LOW_POOL)
    ) u_pool_tracker (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .alloc_idx     (alloc_idx),
        .retire_valid  (retire_valid),
        .retire_idx    (retire_idx),
        .retire_convert(retire_convert),
        .decision      (decision),
        .req_class     (req_class),
        .retire_class  (retire_class)
    );

    mshr_entry_alloc #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_entry_alloc (
        .clk           (clk),
        .rst           (rst),
        .decision      (decision),
        .retire_valid  (retire_valid),
        .retire_idx    (retire_idx),
        .retire_convert(retire_convert),
        .alloc_en      (alloc_en),
        .alloc_idx     (alloc_idx)
    );

    retry_grant_ctrl #(
        .RETRY_CNT_W(RETRY_CNT_W)
    ) u_grant_ctrl (
        .clk           (clk),
        .rst           (rst),
        .decision      (decision),
        .req_class     (req_class),
        .retire_valid  (retire_valid),
        .retire_class  (retire_class),
        .retire_convert(retire_convert),
        .grant_push    (grant_push),
        .grant         (grant_rec)
    );

    rsp_queue #(
        .rec_t(retry_ack_t),
        .DEPTH(QUEUE_DEPTH)
    ) ack_queue (
        .clk  (clk),
        .rst  (rst),
        .push (retry),
        .pop  (retryack_won),
        .din  (ack_rec),
        .dout (retryack),
        .valid(retryack_valid),
        .full ()
    );

    rsp_queue #(
        .rec_t(grant_t),
        .DEPTH(QUEUE_DEPTH)
    ) grant_queue (
        .clk  (clk),
        .rst  (rst),
        .push (grant_push),
        .pop  (pcrdgnt_won),
        .din  (grant_rec),
        .dout (pcrdgnt),
        .valid(pcrdgnt_valid),
        .full ()
    );

endmodule

/* verif/hni_qos_props.sv */
`timescale 1ns/1ns

module hni_qos_props
    import hni_qos_pkg::*;
#(
    parameter int IDX_W = $clog2(DEF_NUM_ENTRIES)
) (
    input logic             clk,
    input logic             rst,
    input logic             retire_valid,
    input logic [IDX_W-1:0] retire_idx,
    input logic             alloc_en,
    input logic [IDX_W-1:0] alloc_idx,
    input logic             retry,
    input logic             retryack_won,
    input logic             retryack_valid,
    input retry_ack_t       retryack,
    input logic             pcrdgnt_won,
    input logic             pcrdgnt_valid,
    input grant_t           pcrdgnt
);

    int fail_count = 0;

    // a request is either admitted or retried
    assert property (@(posedge clk) disable iff (rst) !(alloc_en && retry))
        else begin
            fail_count++;
            $error("alloc_en and retry high together");
        end

    assert property (@(posedge clk) disable iff (rst)
        (retire_valid && alloc_en) |-> (retire_idx != alloc_idx))
        else begin
            fail_count++;
            $error("retire names the entry being allocated");
        end

    // head record is stable until popped
    assert property (@(posedge clk) disable iff (rst)
        (retryack_valid && !retryack_won) |=> (retryack_valid && $stable(retryack)))
        else begin
            fail_count++;
            $error("retry ack record changed before it was won");
        end

    assert property (@(posedge clk) disable iff (rst)
        (pcrdgnt_valid && !pcrdgnt_won) |=> (pcrdgnt_valid && $stable(pcrdgnt)))
        else begin
            fail_count++;
            $error("credit grant record changed before it was won");
        end

endmodule

/* verif/hni_qos_tb.sv */
`timescale 1ns/1ns

module hni_qos_tb
    import hni_qos_pkg::*;
();

    localparam string GOLDEN_FILE = "verif/hni_qos_golden.txt";
    localparam int    IDX_W       = $clog2(DEF_NUM_ENTRIES);

    // one golden line with stimulus then expected outputs
    typedef struct packed {
        logic             req_valid;
        req_flit_t        req;
        logic             retire_valid;
        logic [IDX_W-1:0] retire_idx;
        logic             retryack_won;
        logic             pcrdgnt_won;
        logic             alloc_en;
        logic [IDX_W-1:0] alloc_idx;
        logic             retry;
        logic             ack_valid;
        retry_ack_t       ack;
        logic             gnt_valid;
        grant_t           gnt;
    } golden_vec_t;

    logic             clk;
    logic             rst;
    logic             req_valid;
    req_flit_t        req;
    logic             retire_valid;
    logic [IDX_W-1:0] retire_idx;
    logic             retryack_won;
    logic             pcrdgnt_won;
    logic             alloc_en;
    logic [IDX_W-1:0] alloc_idx;
    logic             retry;
    logic             retryack_valid;
    retry_ack_t       retryack;
    logic             pcrdgnt_valid;
    grant_t           pcrdgnt;

    golden_vec_t vectors [$];
    int          cur_vec;
    int          cycle_cnt = 0;
    int          max_cycles;

    hni_qos_top UUT (.*);

    bind hni_qos_top hni_qos_props #(.IDX_W(IDX_W)) u_props (.*);

    always #10 clk = ~clk;

    // guard against a stalled run
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: %0d cycles passed before the golden vectors ended", cycle_cnt);
            $display("RESULT: FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: vector %0d, %s is %0h, expected %0h",
                     $time, cur_vec, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [22];
        golden_vec_t v;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open golden file %s", GOLDEN_FILE);
            $display("RESULT: FAIL");
            $fatal(1, "missing golden file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                f[21]);
            if (n != 22) begin
                $display("golden line with %0d fields instead of 22: %s", n, line);
                $display("RESULT: FAIL");
                $fatal(1, "malformed golden file");
            end
            v.req_valid     = f[0][0];
            v.req           = '{srcid: f[1][3:0], txnid: f[2][7:0], qos: f[3][3:0],
                                allowretry: f[4][0], tracetag: f[5][0]};
            v.retire_valid  = f[6][0];
            v.retire_idx    = f[7][IDX_W-1:0];
            v.retryack_won  = f[8][0];
            v.pcrdgnt_won   = f[9][0];
            v.alloc_en      = f[10][0];
            v.alloc_idx     = f[11][IDX_W-1:0];
            v.retry         = f[12][0];
            v.ack_valid     = f[13][0];
            v.ack           = '{srcid: f[14][3:0], txnid: f[15][7:0], qos: f[16][3:0],
                                tracetag: f[17][0], pcrdtype: pcrd_type_e'(f[18][1:0])};
            v.gnt_valid     = f[19][0];
            v.gnt           = '{qos: f[20][3:0], pcrdtype: pcrd_type_e'(f[21][1:0])};
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic drive_inputs(input golden_vec_t v);
        req_valid    = v.req_valid;
        req          = v.req;
        retire_valid = v.retire_valid;
        retire_idx   = v.retire_idx;
        retryack_won = v.retryack_won;
        pcrdgnt_won  = v.pcrdgnt_won;
    endtask

    // record fields only matter while the matching valid is high
    task automatic check_outputs(input golden_vec_t v);
        check_value("alloc_en", alloc_en, v.alloc_en);
        if (v.alloc_en) begin
            check_value("alloc_idx", alloc_idx, v.alloc_idx);
        end
        check_value("retry", retry, v.retry);
        check_value("retryack_valid", retryack_valid, v.ack_valid);
        if (v.ack_valid) begin
            check_value("retryack.srcid", retryack.srcid, v.ack.srcid);
            check_value("retryack.txnid", retryack.txnid, v.ack.txnid);
            check_value("retryack.qos", retryack.qos, v.ack.qos);
            check_value("retryack.tracetag", retryack.tracetag, v.ack.tracetag);
            check_value("retryack.pcrdtype", retryack.pcrdtype, v.ack.pcrdtype);
        end
        check_value("pcrdgnt_valid", pcrdgnt_valid, v.gnt_valid);
        if (v.gnt_valid) begin
            check_value("pcrdgnt.qos", pcrdgnt.qos, v.gnt.qos);
            check_value("pcrdgnt.pcrdtype", pcrdgnt.pcrdtype, v.gnt.pcrdtype);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        retire_valid = 1'b0;
        retire_idx   = '0;
        retryack_won = 1'b0;
        pcrdgnt_won  = 1'b0;
        cur_vec      = 0;
        load_golden();
        max_cycles = vectors.size() + 20;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (vectors[i]) begin
            cur_vec = i + 1;
            @(posedge clk);
            #2;
            drive_inputs(vectors[i]);
            // sample just ahead of the next edge
            #17;
            check_outputs(vectors[i]);
        end
        if (UUT.u_props.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("%0d bound assertion failures", UUT.u_props.fail_count);
            $display("RESULT: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* flist.f */
source/hni_qos_pkg.sv
source/qos_pool_tracker.sv
source/mshr_entry_alloc.sv
source/retry_grant_ctrl.sv
source/rsp_queue.sv
source/hni_qos_top.sv
verif/hni_qos_props.sv
verif/hni_qos_tb.sv

/* Bender.yml */
package:
  name: hni_qos

sources:
  # RTL
  - files:
      - source/hni_qos_pkg.sv
      - source/qos_pool_tracker.sv
      - source/mshr_entry_alloc.sv
      - source/retry_grant_ctrl.sv
      - source/rsp_queue.sv
      - source/hni_qos_top.sv
  # verification
  - target: test
    files:
      - verif/hni_qos_props.sv
      - verif/hni_qos_tb.sv

/* verif/hni_qos_golden.txt */
# rv src txn qos ar tt rtv rix awn gwn | ae aix rty av asrc atxn aqos att apc gv gqos gpc
# all fields hex, one line per clock cycle
1 1 01 f 1 0 0 0 0 0  1 0 0 0 0 00 0 0 0 0 0 0
1 1 02 f 1 0 0 0 0 0  1 1 0 0 0 00 0 0 0 0 0 0
1 1 03 f 1 0 0 0 0 0  1 2 0 0 0 00 0 0 0 0 0 0
1 1 04 f 1 0 0 0 0 0  1 3 0 0 0 00 0 0 0 0 0 0
1 1 05 f 1 0 0 0 0 0  1 4 0 0 0 00 0 0 0 0 0 0
1 1 06 f 1 0 0 0 0 0  1 5 0 0 0 00 0 0 0 0 0 0
1 1 07 9 1 0 0 0 0 0  1 6 0 0 0 00 0 0 0 0 0 0
1 1 08 c 1 0 0 0 0 0  1 7 0 0 0 00 0 0 0 0 0 0
0 0 00 0 0 0 1 2 0 0  0 0 0 0 0 00 0 0 0 0 0 0
0 0 00 0 0 0 1 5 0 0  0 0 0 0 0 00 0 0 0 0 0 0
1 2 11 f 1 0 0 0 0 0  1 2 0 0 0 00 0 0 0 0 0 0
1 2 12 3 1 0 0 0 0 0  1 5 0 0 0 00 0 0 0 0 0 0
1 3 13 2 1 1 0 0 0 0  0 0 1 0 0 00 0 0 0 0 0 0
0 0 00 0 0 0 0 0 0 0  0 0 0 1 3 13 2 1 1 0 0 0
0 0 00 0 0 0 0 0 0 0  0 0 0 1 3 13 2 1 1 0 0 0
0 0 00 0 0 0 0 0 1 0  0 0 0 1 3 13 2 1 1 0 0 0
0 0 00 0 0 0 0 0 0 0  0 0 0 0 0 00 0 0 0 0 0 0
0 0 00 0 0 0 1 4 0 0  0 0 0 0 0 00 0 0 0 0 0 0
0 0 00 0 0 0 0 0 0 0  0 0 0 0 0 00 0 0 0 1 0 1
0 0 00 0 0 0 1 6 0 1  0 0 0 0 0 00 0 0 0 1 0 1
1 4 21 1 1 0 0 0 0 0  1 6 0 0 0 00 0 0 0 0 0 0
1 5 22 a 0 0 0 0 0 0  1 4 0 0 0 00 0 0 0 0 0 0
1 6 23 f 1 0 0 0 0 0  0 0 1 0 0 00 0 0 0 0 0 0
1 7 24 0 1 1 0 0 0 0  0 0 1 1 6 23 f 0 2 0 0 0
0 0 00 0 0 0 0 0 1 0  0 0 0 1 6 23 f 0 2 0 0 0
0 0 00 0 0 0 0 0 1 0  0 0 0 1 7 24 0 1 1 0 0 0
0 0 00 0 0 0 1 5 0 0  0 0 0 0 0 00 0 0 0 0 0 0
0 0 00 0 0 0 1 6 0 0  0 0 0 0 0 00 0 0 0 1 f 2
0 0 00 0 0 0 0 0 0 1  0 0 0 0 0 00 0 0 0 1 f 2
0 0 00 0 0 0 0 0 0 1  0 0 0 0 0 00 0 0 0 1 0 1
0 0 00 0 0 0 0 0 0 0  0 0 0 0 0 00 0 0 0 0 0 0
